/* src/ddr2_init_macros.svh */
`ifndef DDR2_INIT_MACROS_SVH
`define DDR2_INIT_MACROS_SVH

// ***************************************************************************
// Power-up timing
// ***************************************************************************

// Cycles from init until CKE is raised (fits a 17-bit count).
`define DDR2_PWRUP_CYCLES 100001

// Hold lengths of the table rows, in clock cycles.
`define DDR2_HOLD_CKE     200   // NOP after CKE rises.
`define DDR2_HOLD_CMD     2     // Any issued command.
`define DDR2_HOLD_MRD     4     // Mode-register set delay.
`define DDR2_HOLD_RP      8     // Precharge period.
`define DDR2_HOLD_RFC     400   // Auto-refresh period.
`define DDR2_HOLD_DLL     406   // DLL lock after MR without reset.

// ***************************************************************************
// Mode-register fields
// ***************************************************************************

`define DDR2_BL           3'b011   // Burst of 8.
`define DDR2_BT           1'b0     // Sequential.
`define DDR2_CL           3'b100
`define DDR2_AL           3'b100
`define DDR2_WR           3'b011

// OCD field codes in EMR A9..A7.
`define DDR2_OCD_EXIT     3'b000
`define DDR2_OCD_DEFAULT  3'b111

// Rows in the step table.
`define DDR2_STEP_COUNT   25

`endif

/* src/ddr2_cmd_pkg.sv */
package ddr2_cmd_pkg;

    // ***********************************************************************
    // Command bus
    // ***********************************************************************

    // Encoded as {cs_n, ras_n, cas_n, we_n}.
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_NOP       = 4'b0111
    } ddr2_cmd_e;

    // Bank select, BA1..BA0.
    typedef logic [1:0] ddr2_bank_t;

    // Row or mode-register address, A12..A0.
    typedef logic [12:0] ddr2_addr_t;

    // ***********************************************************************
    // Wait timing
    // ***********************************************************************

    // Wide enough for the power-up wait.
    typedef logic [16:0] ddr2_count_t;

endpackage

/* src/ddr2_seq_pkg.sv */
package ddr2_seq_pkg;

    // Sequencer phases.
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,   // Waiting for init.
        ST_PWRUP = 2'd1,   // Power-up delay, CKE low.
        ST_STEP  = 2'd2,   // Walking the command table.
        ST_DONE  = 2'd3    // Initialized, NOP forever.
    } ddr2_seq_state_e;

    // Index into the step table.
    typedef logic [4:0] ddr2_step_t;

endpackage

/* src/ddr2_init_steps.sv */
`timescale 1ns/1ps
`include "ddr2_init_macros.svh"

module ddr2_init_steps (
    input  ddr2_seq_pkg::ddr2_step_t   step,
    output ddr2_cmd_pkg::ddr2_cmd_e    step_cmd,
    output ddr2_cmd_pkg::ddr2_bank_t   step_bank,
    output ddr2_cmd_pkg::ddr2_addr_t   step_addr,
    output ddr2_cmd_pkg::ddr2_count_t  step_hold
);

    // MR: WR in A11..A9, DLL reset in A8, CL, BT, BL.
    localparam ddr2_cmd_pkg::ddr2_addr_t mr_dll_reset =
        {1'b0, `DDR2_WR, 1'b1, 1'b0, `DDR2_CL, `DDR2_BT, `DDR2_BL};
    localparam ddr2_cmd_pkg::ddr2_addr_t mr_normal =
        {1'b0, `DDR2_WR, 1'b0, 1'b0, `DDR2_CL, `DDR2_BT, `DDR2_BL};

    // EMR: A10 high, OCD in A9..A7, AL in A5..A3, DLL enabled.
    localparam ddr2_cmd_pkg::ddr2_addr_t emr_ocd_exit =
        {2'b00, 1'b1, `DDR2_OCD_EXIT, 1'b0, `DDR2_AL, 3'b000};
    localparam ddr2_cmd_pkg::ddr2_addr_t emr_ocd_default =
        {2'b00, 1'b1, `DDR2_OCD_DEFAULT, 1'b0, `DDR2_AL, 3'b000};

    localparam ddr2_cmd_pkg::ddr2_addr_t prech_all = 13'h0400;   // A10 selects all banks.

    // ***********************************************************************
    // JEDEC initialization order
    // ***********************************************************************

    always_comb begin
        step_cmd  = ddr2_cmd_pkg::CMD_NOP;
        step_bank = '0;
        step_addr = '0;
        step_hold = ddr2_cmd_pkg::ddr2_count_t'(`DDR2_HOLD_MRD);
        case (step)
            5'd0:  step_hold = ddr2_cmd_pkg::ddr2_count_t'(`DDR2_HOLD_CKE);
            5'd2,
            5'd12,
            5'd24: step_hold = ddr2_cmd_pkg::ddr2_count_t'(`DDR2_HOLD_RP);
            5'd14,
            5'd16: step_hold = ddr2_cmd_pkg::ddr2_count_t'(`DDR2_HOLD_RFC);
            5'd18: step_hold = ddr2_cmd_pkg::ddr2_count_t'(`DDR2_HOLD_DLL);
            5'd4, 5'd6, 5'd8, 5'd10, 5'd20, 5'd22: ;   // NOP for tMRD.
            5'd1,
            5'd11,
            5'd23: begin
                step_cmd  = ddr2_cmd_pkg::CMD_PRECHARGE;
                step_addr = prech_all;
            end
            5'd3:  begin
                step_cmd  = ddr2_cmd_pkg::CMD_LOAD_MODE;
                step_bank = 2'd2;   // EMR2.
            end
            5'd5:  begin
                step_cmd  = ddr2_cmd_pkg::CMD_LOAD_MODE;
                step_bank = 2'd3;   // EMR3.
            end
            5'd7,
            5'd21: begin
                step_cmd  = ddr2_cmd_pkg::CMD_LOAD_MODE;
                step_bank = 2'd1;
                step_addr = emr_ocd_exit;
            end
            5'd9:  begin
                step_cmd  = ddr2_cmd_pkg::CMD_LOAD_MODE;
                step_addr = mr_dll_reset;
            end
            5'd13,
            5'd15: step_cmd = ddr2_cmd_pkg::CMD_REFRESH;
            5'd17: begin
                step_cmd  = ddr2_cmd_pkg::CMD_LOAD_MODE;
                step_addr = mr_normal;
            end
            5'd19: begin
                step_cmd  = ddr2_cmd_pkg::CMD_LOAD_MODE;
                step_bank = 2'd1;
                step_addr = emr_ocd_default;
            end
            default: step_hold = ddr2_cmd_pkg::ddr2_count_t'(1);
        endcase

        // Command rows share one hold length.
        if (step_cmd != ddr2_cmd_pkg::CMD_NOP) begin
            step_hold = ddr2_cmd_pkg::ddr2_count_t'(`DDR2_HOLD_CMD);
        end
    end

endmodule

/* src/ddr2_wait_timer.sv */
`timescale 1ns/1ps

module ddr2_wait_timer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       load,
    input  ddr2_cmd_pkg::ddr2_count_t  count,
    output logic                       expired
);

    ddr2_cmd_pkg::ddr2_count_t remaining;

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= count;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;   // Stops at zero.
        end
    end

    // Held high while the count rests at zero.
    assign expired = (remaining == '0);

endmodule

/* src/ddr2_init_fsm.sv */
`timescale 1ns/1ps
`include "ddr2_init_macros.svh"

module ddr2_init_fsm (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       init,
    input  logic                       expired,
    input  ddr2_cmd_pkg::ddr2_cmd_e    step_cmd,
    input  ddr2_cmd_pkg::ddr2_bank_t   step_bank,
    input  ddr2_cmd_pkg::ddr2_addr_t   step_addr,
    input  ddr2_cmd_pkg::ddr2_count_t  step_hold,
    output ddr2_seq_pkg::ddr2_step_t   step,
    output logic                       load,
    output ddr2_cmd_pkg::ddr2_count_t  count,
    output logic                       ready,
    output logic                       cs_n,
    output logic                       ras_n,
    output logic                       cas_n,
    output logic                       we_n,
    output logic                       cke,
    output logic                       odt,
    output ddr2_cmd_pkg::ddr2_bank_t   ba,
    output ddr2_cmd_pkg::ddr2_addr_t   a
);

    ddr2_seq_pkg::ddr2_seq_state_e state;
    ddr2_cmd_pkg::ddr2_cmd_e       cmd_q;
    logic                          last_row;
    logic                          issue;
    logic                          issue_addr;

    // The step register runs one row ahead of the pins.
    assign last_row   = (step == ddr2_seq_pkg::ddr2_step_t'(`DDR2_STEP_COUNT));
    assign issue      = load && (state != ddr2_seq_pkg::ST_IDLE);
    assign issue_addr = (step_cmd == ddr2_cmd_pkg::CMD_LOAD_MODE) ||
                        (step_cmd == ddr2_cmd_pkg::CMD_PRECHARGE);

    assign {cs_n, ras_n, cas_n, we_n} = cmd_q;

    // ***********************************************************************
    // Timer loads
    // ***********************************************************************

    always_comb begin
        load  = 1'b0;
        count = step_hold - ddr2_cmd_pkg::ddr2_count_t'(1);
        case (state)
            ddr2_seq_pkg::ST_IDLE: begin
                load  = init;
                count = ddr2_cmd_pkg::ddr2_count_t'(`DDR2_PWRUP_CYCLES - 1);
            end
            ddr2_seq_pkg::ST_PWRUP: load = expired;
            ddr2_seq_pkg::ST_STEP:  load = expired && !last_row;
            default:                load = 1'b0;
        endcase
    end

    // ***********************************************************************
    // Phase control
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ddr2_seq_pkg::ST_IDLE;
            cke   <= 1'b0;
            odt   <= 1'b0;
            ready <= 1'b0;
        end else begin
            case (state)
                ddr2_seq_pkg::ST_IDLE: begin
                    if (init) state <= ddr2_seq_pkg::ST_PWRUP;
                end
                ddr2_seq_pkg::ST_PWRUP: begin
                    if (expired) begin
                        cke   <= 1'b1;
                        state <= ddr2_seq_pkg::ST_STEP;
                    end
                end
                ddr2_seq_pkg::ST_STEP: begin
                    if (expired && last_row) begin
                        odt   <= 1'b1;
                        ready <= 1'b1;
                        state <= ddr2_seq_pkg::ST_DONE;
                    end
                end
                default: ;   // ST_DONE holds until reset.
            endcase
        end
    end

    // Command and address registers.
    always_ff @(posedge clk) begin
        if (reset) begin
            step  <= '0;
            cmd_q <= ddr2_cmd_pkg::CMD_NOP;
            ba    <= '0;
            a     <= '0;
        end else if (issue) begin
            cmd_q <= step_cmd;
            step  <= step + ddr2_seq_pkg::ddr2_step_t'(1);
            if (issue_addr) begin
                ba <= step_bank;
                a  <= step_addr;
            end
        end else if (state == ddr2_seq_pkg::ST_DONE) begin
            cmd_q <= ddr2_cmd_pkg::CMD_NOP;
        end
    end

endmodule

/* src/ddr2_init_top.sv */
`timescale 1ns/1ps

module ddr2_init_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      init,
    output logic                      ready,
    output logic                      cs_n,
    output logic                      ras_n,
    output logic                      cas_n,
    output logic                      we_n,
    output ddr2_cmd_pkg::ddr2_bank_t  ba,
    output ddr2_cmd_pkg::ddr2_addr_t  a,
    output logic                      cke,
    output logic                      odt
);

    ddr2_seq_pkg::ddr2_step_t   step;
    ddr2_cmd_pkg::ddr2_cmd_e    step_cmd;
    ddr2_cmd_pkg::ddr2_bank_t   step_bank;
    ddr2_cmd_pkg::ddr2_addr_t   step_addr;
    ddr2_cmd_pkg::ddr2_count_t  step_hold;
    logic                       load;
    ddr2_cmd_pkg::ddr2_count_t  count;
    logic                       expired;

    ddr2_init_steps u_steps (
        .step      (step),
        .step_cmd  (step_cmd),
        .step_bank (step_bank),
        .step_addr (step_addr),
        .step_hold (step_hold)
    );

    ddr2_wait_timer u_timer (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .count   (count),
        .expired (expired)
    );

    ddr2_init_fsm u_fsm (
        .clk       (clk),
        .reset     (reset),
        .init      (init),
        .expired   (expired),
        .step_cmd  (step_cmd),
        .step_bank (step_bank),
        .step_addr (step_addr),
        .step_hold (step_hold),
        .step      (step),
        .load      (load),
        .count     (count),
        .ready     (ready),
        .cs_n      (cs_n),
        .ras_n     (ras_n),
        .cas_n     (cas_n),
        .we_n      (we_n),
        .cke       (cke),
        .odt       (odt),
        .ba        (ba),
        .a         (a)
    );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period.
    end

    // Held for four rising edges, released on a falling edge.
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* bench/ddr2_init_tb.sv */
`timescale 1ns/1ps
`include "ddr2_init_macros.svh"

module ddr2_init_tb;

    localparam logic [3:0] LOAD_MODE = 4'b0000;
    localparam logic [3:0] PRECHARGE = 4'b0010;
    localparam logic [3:0] NOP       = 4'b0111;

    logic        clk, reset, init, ready, cke, odt;
    logic        cs_n, ras_n, cas_n, we_n;
    logic [1:0]  ba;
    logic [12:0] a;
    logic [3:0]  gold_cmd  [`DDR2_STEP_COUNT];
    logic [1:0]  gold_bank [`DDR2_STEP_COUNT];
    logic [12:0] gold_addr [`DDR2_STEP_COUNT];
    int          gold_hold [`DDR2_STEP_COUNT];
    int          pwrup_count = 0;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    bit          golden_ok = 1'b0;
    int          current_test = 1;
    int          test_errors [1:5];
    int          pass_count = 0;
    int          fail_count = 0;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    ddr2_init_top DUT (
        .clk   (clk),
        .reset (reset),
        .init  (init),
        .ready (ready),
        .cs_n  (cs_n),
        .ras_n (ras_n),
        .cas_n (cas_n),
        .we_n  (we_n),
        .ba    (ba),
        .a     (a),
        .cke   (cke),
        .odt   (odt)
    );

    function automatic logic [3:0] command_pins();
        return {cs_n, ras_n, cas_n, we_n};
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            test_errors[current_test]++;
        end
    endtask

    task automatic report_test(string title);
        if (test_errors[current_test] == 0) begin
            pass_count++;
            $display("Test %0d %s: pass", current_test, title);
        end else begin
            fail_count++;
            $display("Test %0d %s: %0d mismatches", current_test, title,
                     test_errors[current_test]);
        end
    endtask

    // ***********************************************************************
    // Golden trace
    // ***********************************************************************

    task automatic load_golden();
        int          fd;
        int          row;
        int          hold_total;
        logic [3:0]  cmd_v;
        logic [1:0]  bank_v;
        logic [12:0] addr_v;
        int          hold_v;
        string       line;
        row = -1;   // Power-up count comes first.
        hold_total = 0;
        fd = $fopen("bench/ddr2_init_golden.txt", "r");
        if (fd != 0) begin
            while (row < `DDR2_STEP_COUNT && $fgets(line, fd) != 0) begin
                if (row < 0) begin
                    if ($sscanf(line, "%d", pwrup_count) == 1) row = 0;
                end else if ($sscanf(line, "%h %h %h %d", cmd_v, bank_v, addr_v,
                                     hold_v) == 4) begin
                    gold_cmd[row]  = cmd_v;
                    gold_bank[row] = bank_v;
                    gold_addr[row] = addr_v;
                    gold_hold[row] = hold_v;
                    hold_total += hold_v;
                    row++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = pwrup_count + hold_total + 200;
        golden_ok = (row == `DDR2_STEP_COUNT);
    endtask

    // ***********************************************************************
    // Tests
    // ***********************************************************************

    task automatic idle_after_reset();
        current_test = 1;
        repeat (20) begin
            @(negedge clk);
            check_value("cke", cke, 0);
            check_value("odt", odt, 0);
            check_value("ready", ready, 0);
            check_value("cmd", command_pins(), NOP);
            check_value("ba", ba, 0);
            check_value("a", a, 0);
        end
        report_test("reset and idle");
    endtask

    task automatic power_up_wait();
        int edges;
        current_test = 2;
        init = 1'b1;   // One pulse, seen by the next rising edge.
        @(negedge clk);
        init = 1'b0;
        edges = 0;
        while (cke !== 1'b1) begin
            check_value("cmd", command_pins(), NOP);
            check_value("ready", ready, 0);
            check_value("odt", odt, 0);
            @(negedge clk);
            edges++;
        end
        check_value("cke rise edges", edges, pwrup_count);
        report_test("power-up wait");
    endtask

    task automatic walk_table();
        logic [18:0] row_bus;
        logic [1:0]  exp_ba;
        logic [12:0] exp_a;
        int          run;
        int          k;
        exp_ba = '0;
        exp_a = '0;
        for (k = 0; k < `DDR2_STEP_COUNT; k++) begin
            current_test = 3;
            if (gold_cmd[k] == LOAD_MODE || gold_cmd[k] == PRECHARGE) begin
                exp_ba = gold_bank[k];   // Address bus moves only here.
                exp_a  = gold_addr[k];
            end
            check_value($sformatf("cmd row %0d", k), command_pins(), gold_cmd[k]);
            check_value($sformatf("ba row %0d", k), ba, exp_ba);
            check_value($sformatf("a row %0d", k), a, exp_a);
            check_value("cke", cke, 1);
            check_value("ready", ready, 0);
            row_bus = {command_pins(), ba, a};
            run = 0;
            while ({command_pins(), ba, a} === row_bus && ready === 1'b0) begin
                check_value("odt", odt, 0);
                run++;
                @(negedge clk);
            end
            current_test = 4;
            check_value($sformatf("hold row %0d", k), run, gold_hold[k]);
        end
        current_test = 3;
        report_test("command order and contents");
        current_test = 4;
        report_test("hold lengths");
    endtask

    task automatic completion_hold();
        current_test = 5;
        check_value("ready", ready, 1);   // Same edge as odt.
        check_value("odt", odt, 1);
        check_value("cmd", command_pins(), NOP);
        repeat (50) begin
            init = ~init;
            @(negedge clk);
            check_value("ready", ready, 1);
            check_value("odt", odt, 1);
            check_value("cke", cke, 1);
            check_value("cmd", command_pins(), NOP);
        end
        init = 1'b0;
        report_test("completion");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (golden_ok && cycle_count > cycle_limit) begin
            $display("Timeout: the init sequence did not finish in %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        init = 1'b0;
        load_golden();
        if (!golden_ok) begin
            $display("Could not read the golden trace bench/ddr2_init_golden.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            wait (reset == 1'b0);
            idle_after_reset();
            power_up_wait();
            walk_table();
            completion_hold();
            $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

/* bench/ddr2_init_golden.txt */
// First value: power-up wait in cycles before cke rises (decimal).
// Then one row per step: command {cs_n,ras_n,cas_n,we_n} (hex), bank (hex),
// address (hex), hold cycles (decimal). Bank and address matter for 0 and 2 only.
100001
7 0 000 200
2 0 400 2     // Precharge all.
7 0 000 8
0 2 000 2     // EMR2.
7 0 000 4
0 3 000 2     // EMR3.
7 0 000 4
0 1 420 2     // EMR, DLL enabled.
7 0 000 4
0 0 743 2     // MR with DLL reset.
7 0 000 4
2 0 400 2     // Precharge all.
7 0 000 8
1 0 000 2     // Auto-refresh.
7 0 000 400
1 0 000 2     // Auto-refresh.
7 0 000 400
0 0 643 2     // MR without DLL reset.
7 0 000 406
0 1 7a0 2     // EMR, OCD default.
7 0 000 4
0 1 420 2     // EMR, OCD exit.
7 0 000 4
2 0 400 2     // Precharge all.
7 0 000 8

/* ddr2_init.f */
+incdir+src
src/ddr2_cmd_pkg.sv
src/ddr2_seq_pkg.sv
src/ddr2_init_steps.sv
src/ddr2_wait_timer.sv
src/ddr2_init_fsm.sv
src/ddr2_init_top.sv
bench/tb_clock_gen.sv
bench/ddr2_init_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the DDR2 init testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module ddr2_init_tb -f ddr2_init.f -o ddr2_init_sim
output=$(./obj_dir/ddr2_init_sim)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
